// ==== Makefile ====
# Verilator simulation of the location counter slice

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert -f lc_subsys.f --top-module lc_tb -o lc_tb_sim
	@out=$$(./obj_dir/lc_tb_sim); echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== hw/lc_counter.sv ====
////////////////////////////////////////////////////////////
// byte address of the macroinstruction stream
// updates only on fetch, load from ob wins over increment
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lc_counter
#(
   parameter lc_pkg::lc_addr_t reset_lc = '0
)
(
   input  logic             clk,
   input  logic             reset,
   input  logic             fetch,
   input  logic             destlc,
   input  logic             lcinc,
   input  logic             lc_byte_mode,
   input  lc_pkg::word_t    ob,
   output lc_pkg::lc_addr_t lc,
   output logic [3:0]       lca,
   output logic             lcry3
);

   import lc_pkg::*;

   logic [4:0] nibble_sum;
   lc_addr_t   lc_next;

   // +2 in halfword mode, +1 in byte mode
   assign nibble_sum = {1'b0, lc[3:0]}
                     + {4'b0, lcinc & ~lc_byte_mode}
                     + {4'b0, lcinc};

   // carry out means the next word must be fetched
   assign {lcry3, lca} = nibble_sum;

   // carry ripples into the upper 22 bits
   assign lc_next = {lc[25:4] + {21'b0, lcry3}, lca};

   always_ff @(posedge clk)
   begin
      if (reset)
         lc <= reset_lc;
      else if (fetch)
      begin
         if (destlc)
            lc <= ob[25:0];
         else if (lcinc)
            lc <= lc_next;
      end
   end

endmodule

`default_nettype wire

// ==== hw/lc_cycle_seq.sv ====
////////////////////////////////////////////////////////////
// four state machine cycle, exactly one strobe high
// hold freezes the state, there is no other stall
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lc_cycle_seq
(
   input  logic               clk,
   input  logic               reset,
   input  logic               hold,
   output lc_pkg::cyc_strobe_t strobe,
   output lc_pkg::cyc_state_e  state
);

   import lc_pkg::*;

   cyc_state_e state_q;
   cyc_state_e state_next;

   // fixed rotation alu, write, mmu, fetch
   always_comb
   begin
      unique case (state_q)
         cyc_alu:   state_next = cyc_write;
         cyc_write: state_next = cyc_mmu;
         cyc_mmu:   state_next = cyc_fetch;
         cyc_fetch: state_next = cyc_alu;
         default:   state_next = cyc_alu;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state_q <= cyc_alu;
      else if (!hold)
         state_q <= state_next;
   end

   // one-hot decode for the rest of the datapath
   always_comb
   begin
      strobe       = '0;
      strobe.alu   = (state_q == cyc_alu);
      strobe.write = (state_q == cyc_write);
      strobe.mmu   = (state_q == cyc_mmu);
      strobe.fetch = (state_q == cyc_fetch);
   end

   assign state = state_q;

endmodule

`default_nettype wire

// ==== hw/lc_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types for the location counter slice
// widths follow the microcoded datapath, mf is 32 bits
////////////////////////////////////////////////////////////
`default_nettype none

package lc_pkg;

   // bus and address widths
   typedef logic [31:0] word_t;
   typedef logic [25:0] lc_addr_t;
   typedef logic [13:0] opc_t;
   typedef logic [9:0]  ptr10_t;
   typedef logic [23:0] vmo_t;
   typedef logic [4:0]  vmap_t;

   // machine cycle, rotates in this order
   typedef enum logic [1:0] {
      cyc_alu   = 2'd0,
      cyc_write = 2'd1,
      cyc_mmu   = 2'd2,
      cyc_fetch = 2'd3
   } cyc_state_e;

   typedef struct packed {
      logic alu;
      logic write;
      logic mmu;
      logic fetch;
   } cyc_strobe_t;

   // bits that land in the lc status word
   typedef struct packed {
      logic needfetch;
      logic lc_byte_mode;
      logic prog_unibus_reset;
      logic int_enable;
      logic sequence_break;
      logic lc0b;
   } lc_status_t;

   // drive requests, listed in priority order
   typedef struct packed {
      logic srclc;
      logic opcdrive;
      logic dcdrive;
      logic ppdrive;
      logic pidrive;
      logic qdrive;
      logic mddrive;
      logic vmadrive;
      logic mapdrive;
   } mf_sel_t;

   typedef struct packed {
      opc_t   opc;
      ptr10_t dc;
      ptr10_t pdlptr;
      ptr10_t pdlidx;
      word_t  q;
      word_t  md;
      word_t  vma;
      vmap_t  vmap;
      vmo_t   vmo;
      logic   pfr;
      logic   pfw;
   } mf_src_t;

endpackage

`default_nettype wire

// ==== hw/lc_top.sv ====
////////////////////////////////////////////////////////////
// location counter slice, alu and memories sit outside
// reset_lc sets the boot address of the counter
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lc_top
#(
   parameter lc_pkg::lc_addr_t reset_lc = '0
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               hold,
   input  logic               destlc,
   input  logic               lcinc,
   input  lc_pkg::word_t      ob,
   input  lc_pkg::mf_sel_t    sel,
   input  lc_pkg::mf_src_t    src,
   input  lc_pkg::lc_status_t status,
   output lc_pkg::lc_addr_t   lc,
   output logic [3:0]         lca,
   output logic               lcry3,
   output logic               lcdrive,
   output lc_pkg::word_t      mf,
   output lc_pkg::cyc_state_e state
);

   import lc_pkg::*;

   cyc_strobe_t strobe;
   logic        lc_byte_mode;

   // increment size comes from the status bits
   assign lc_byte_mode = status.lc_byte_mode;

   lc_cycle_seq u_seq
   (
      .clk    (clk),
      .reset  (reset),
      .hold   (hold),
      .strobe (strobe),
      .state  (state)
   );

   lc_counter #(.reset_lc(reset_lc)) u_counter
   (
      .clk          (clk),
      .reset        (reset),
      .fetch        (strobe.fetch),
      .destlc       (destlc),
      .lcinc        (lcinc),
      .lc_byte_mode (lc_byte_mode),
      .ob           (ob),
      .lc           (lc),
      .lca          (lca),
      .lcry3        (lcry3)
   );

   mf_source_mux u_mf_mux
   (
      .strobe  (strobe),
      .sel     (sel),
      .src     (src),
      .lc      (lc),
      .status  (status),
      .lcdrive (lcdrive),
      .mf      (mf)
   );

endmodule

`default_nettype wire

// ==== hw/mf_source_mux.sv ====
////////////////////////////////////////////////////////////
// fixed priority onto mf, lc first and map last
// narrow sources are zero extended, mf is 0 when idle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mf_source_mux
(
   input  lc_pkg::cyc_strobe_t strobe,
   input  lc_pkg::mf_sel_t     sel,
   input  lc_pkg::mf_src_t     src,
   input  lc_pkg::lc_addr_t    lc,
   input  lc_pkg::lc_status_t  status,
   output logic                lcdrive,
   output lc_pkg::word_t       mf
);

   import lc_pkg::*;

   word_t status_word;
   word_t map_word;

   // the strobe is what actually gates the bus
   assign lcdrive = sel.srclc
                  & (strobe.alu | strobe.write | strobe.mmu | strobe.fetch);

   // lc bit 0 is replaced by lc0b
   assign status_word = {status.needfetch,
                         1'b0,
                         status.lc_byte_mode,
                         status.prog_unibus_reset,
                         status.int_enable,
                         status.sequence_break,
                         lc[25:1],
                         status.lc0b};

   // access bits are stored inverted in the map
   assign map_word = {~src.pfw,
                      ~src.pfr,
                      1'b1,
                      src.vmap,
                      src.vmo};

   always_comb
   begin
      if (lcdrive)
         mf = status_word;
      else if (sel.opcdrive)
         mf = {18'b0, src.opc};
      else if (sel.dcdrive)
         mf = {22'b0, src.dc};
      else if (sel.ppdrive)
         mf = {22'b0, src.pdlptr};
      else if (sel.pidrive)
         mf = {22'b0, src.pdlidx};
      else if (sel.qdrive)
         mf = src.q;
      else if (sel.mddrive)
         mf = src.md;
      else if (sel.vmadrive)
         mf = src.vma;
      else if (sel.mapdrive)
         mf = map_word;
      else
         mf = '0;
   end

endmodule

`default_nettype wire

// ==== lc_subsys.f ====
hw/lc_pkg.sv
hw/lc_cycle_seq.sv
hw/lc_counter.sv
hw/mf_source_mux.sv
hw/lc_top.sv
verif/lc_clkgen.sv
verif/lc_props.sv
verif/lc_tb.sv

// ==== verif/lc_clkgen.sv ====
////////////////////////////////////////////////////////////
// free running clock and synchronous reset for the testbench
// reset drops on a falling edge after reset_cycles edges
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lc_clkgen
#(
   parameter int half_period  = 50,
   parameter int reset_cycles = 3
)
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

// ==== verif/lc_props.sv ====
////////////////////////////////////////////////////////////
// concurrent checks on the strobes and the location counter
// bound into lc_top, where both are visible
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lc_props
#(
   parameter lc_pkg::lc_addr_t reset_lc = '0
)
(
   input logic                clk,
   input logic                reset,
   input lc_pkg::cyc_strobe_t strobe,
   input lc_pkg::lc_addr_t    lc
);

   int unsigned fail_count = 0;

   // exactly one machine state at a time
   strobe_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(strobe))
   else
   begin
      fail_count++;
      $error("more or less than one state strobe is high");
   end

   // lc moves only on the edge that closes a fetch cycle
   lc_after_fetch: assert property (@(posedge clk) disable iff (reset)
      (!$past(reset) && $changed(lc)) |-> $past(strobe.fetch))
   else
   begin
      fail_count++;
      $error("lc changed outside the cycle after fetch");
   end

   lc_reset_value: assert property (@(posedge clk) $fell(reset) |-> lc == reset_lc)
   else
   begin
      fail_count++;
      $error("lc does not hold the boot address after reset");
   end

endmodule

bind lc_top lc_props #(.reset_lc(reset_lc)) u_props
(
   .clk    (clk),
   .reset  (reset),
   .strobe (strobe),
   .lc     (lc)
);

`default_nettype wire

// ==== verif/lc_tb.sv ====
////////////////////////////////////////////////////////////
// directed tests for lc_top against a cycle model
// inputs change on the falling edge, outputs checked there
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lc_tb;

   import lc_pkg::*;

   localparam lc_addr_t boot_lc = 26'h123c;

   // test lengths in cycles, the timeout is twice their sum
   localparam int reset_cycles   = 3;
   localparam int rot_cycles     = 17;
   localparam int inc_fetches    = 48;
   localparam int wrap_fetches   = 8;
   localparam int load_rounds    = 16;
   localparam int prio_vectors   = 300;
   localparam int word_vectors   = 40;
   localparam int test_cycles    = reset_cycles + rot_cycles + 3 * 4
                                 + 4 * (2 * inc_fetches + wrap_fetches)
                                 + 8 * load_rounds + prio_vectors + 2 * word_vectors;
   localparam int timeout_cycles = 2 * test_cycles;

   logic       clk;
   logic       reset;
   logic       hold;
   logic       destlc;
   logic       lcinc;
   word_t      ob;
   mf_sel_t    sel;
   mf_src_t    src;
   lc_status_t status;
   lc_addr_t   dut_lc;
   logic [3:0] dut_lca;
   logic       dut_lcry3;
   logic       dut_lcdrive;
   word_t      dut_mf;
   cyc_state_e dut_state;

   // reference model state
   lc_addr_t    model_lc = boot_lc;
   cyc_state_e  model_state = cyc_alu;
   int          errors = 0;
   int unsigned cycle_count = 0;

   lc_clkgen #(.half_period(50), .reset_cycles(reset_cycles)) u_clkgen
   (
      .clk   (clk),
      .reset (reset)
   );

   lc_top #(.reset_lc(boot_lc)) dut
   (
      .clk     (clk),
      .reset   (reset),
      .hold    (hold),
      .destlc  (destlc),
      .lcinc   (lcinc),
      .ob      (ob),
      .sel     (sel),
      .src     (src),
      .status  (status),
      .lc      (dut_lc),
      .lca     (dut_lca),
      .lcry3   (dut_lcry3),
      .lcdrive (dut_lcdrive),
      .mf      (dut_mf),
      .state   (dut_state)
   );

   function automatic cyc_state_e next_state(cyc_state_e cur);
      case (cur)
         cyc_alu:   return cyc_write;
         cyc_write: return cyc_mmu;
         cyc_mmu:   return cyc_fetch;
         default:   return cyc_alu;
      endcase
   endfunction

   // low nibble plus step, bit 4 is the carry
   function automatic logic [4:0] nibble_sum(lc_addr_t cur, logic inc, logic byte_mode);
      int step;
      step = inc ? (byte_mode ? 1 : 2) : 0;
      return 5'(int'(cur[3:0]) + step);
   endfunction

   function automatic word_t status_word_of(lc_addr_t cur, lc_status_t st);
      word_t w;
      w       = '0;
      w[31]   = st.needfetch;
      w[29]   = st.lc_byte_mode;
      w[28]   = st.prog_unibus_reset;
      w[27]   = st.int_enable;
      w[26]   = st.sequence_break;
      w[25:1] = cur[25:1];
      w[0]    = st.lc0b;
      return w;
   endfunction

   function automatic word_t map_word_of(mf_src_t d);
      word_t w;
      w        = '0;
      w[31]    = ~d.pfw;
      w[30]    = ~d.pfr;
      w[29]    = 1'b1;
      w[28:24] = d.vmap;
      w[23:0]  = d.vmo;
      return w;
   endfunction

   // walk up from the lowest priority, a later hit wins
   function automatic word_t expected_mf(mf_sel_t s, mf_src_t d, lc_addr_t cur,
                                         lc_status_t st);
      word_t w;
      w = '0;
      if (s.mapdrive)
         w = map_word_of(d);
      if (s.vmadrive)
         w = d.vma;
      if (s.mddrive)
         w = d.md;
      if (s.qdrive)
         w = d.q;
      if (s.pidrive)
         w = word_t'(d.pdlidx);
      if (s.ppdrive)
         w = word_t'(d.pdlptr);
      if (s.dcdrive)
         w = word_t'(d.dc);
      if (s.opcdrive)
         w = word_t'(d.opc);
      if (s.srclc)
         w = status_word_of(cur, st);
      return w;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected)
      begin
         errors++;
         $display("** Error [%s] at %0t: expected 0x%h, actual 0x%h",
                  name, $time, expected, actual);
      end
   endtask

   // one machine cycle, entered and left at a falling edge
   task automatic run_cycle(input string name);
      logic [4:0] sum;
      #10;
      sum = nibble_sum(model_lc, lcinc, status.lc_byte_mode);
      check({name, " lca"}, 32'(sum[3:0]), 32'(dut_lca));
      check({name, " lcry3"}, 32'(sum[4]), 32'(dut_lcry3));
      check({name, " lcdrive"}, 32'(sel.srclc), 32'(dut_lcdrive));
      check({name, " mf"}, expected_mf(sel, src, model_lc, status), dut_mf);
      @(posedge clk);
      if (model_state == cyc_fetch)
      begin
         if (destlc)
            model_lc = ob[25:0];
         else if (lcinc)
            model_lc = model_lc + (status.lc_byte_mode ? 26'd1 : 26'd2);
      end
      if (!hold)
         model_state = next_state(model_state);
      @(negedge clk);
      check({name, " state"}, 32'(model_state), 32'(dut_state));
      check({name, " lc"}, 32'(model_lc), 32'(dut_lc));
   endtask

   // upper ob bits are random and must be ignored
   task automatic load_lc(input string name, input lc_addr_t value);
      logic at_fetch;
      destlc   = 1'b1;
      ob       = {6'($urandom), value};
      at_fetch = 1'b0;
      while (!at_fetch)
      begin
         at_fetch = (model_state == cyc_fetch);
         run_cycle(name);
      end
      destlc = 1'b0;
   endtask

   task automatic randomize_sources();
      src.opc    = opc_t'($urandom);
      src.dc     = ptr10_t'($urandom);
      src.pdlptr = ptr10_t'($urandom);
      src.pdlidx = ptr10_t'($urandom);
      src.q      = $urandom;
      src.md     = $urandom;
      src.vma    = $urandom;
      src.vmap   = vmap_t'($urandom);
      src.vmo    = vmo_t'($urandom);
      src.pfr    = 1'($urandom);
      src.pfw    = 1'($urandom);
   endtask

   task automatic rotation_test();
      cyc_state_e frozen;
      hold = 1'b0;
      repeat (8) run_cycle("rotation");
      hold   = 1'b1;
      frozen = model_state;
      repeat (5)
      begin
         run_cycle("hold");
         check("hold frozen", 32'(frozen), 32'(dut_state));
      end
      hold = 1'b0;
      repeat (4) run_cycle("rotation after hold");
   endtask

   task automatic increment_test(input string name, input logic byte_mode,
                                 input lc_addr_t start, input int fetches);
      lcinc               = 1'b0;
      status.lc_byte_mode = byte_mode;
      load_lc(name, start);
      lcinc = 1'b1;
      repeat (4 * fetches) run_cycle(name);
      lcinc = 1'b0;
   endtask

   task automatic load_test(input int rounds);
      // destlc every cycle with fresh ob, only the fetch value sticks
      destlc = 1'b1;
      lcinc  = 1'b1;
      repeat (4 * rounds)
      begin
         ob = $urandom;
         run_cycle("load at fetch");
      end
      lcinc = 1'b0;
      repeat (4 * rounds)
      begin
         ob     = $urandom;
         destlc = (model_state != cyc_fetch);
         run_cycle("load outside fetch");
      end
      destlc = 1'b0;
   endtask

   task automatic priority_test(input int vectors);
      int i;
      for (i = 0; i < vectors; i++)
      begin
         randomize_sources();
         status = 6'($urandom);
         if (i % 10 == 0)
            sel = '0;
         else
            sel = 9'($urandom & $urandom);
         run_cycle("priority");
      end
      sel = '0;
   endtask

   task automatic word_layout_test(input int vectors);
      lcinc = 1'b1;
      repeat (vectors)
      begin
         randomize_sources();
         status    = 6'($urandom);
         sel       = '0;
         sel.srclc = 1'b1;
         run_cycle("status word");
      end
      lcinc = 1'b0;
      repeat (vectors)
      begin
         randomize_sources();
         sel          = '0;
         sel.mapdrive = 1'b1;
         run_cycle("map word");
      end
      sel = '0;
   endtask

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= timeout_cycles)
      begin
         $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
         $display("errors: %0d", errors);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial
   begin
      int total;
      hold   = 1'b0;
      destlc = 1'b0;
      lcinc  = 1'b0;
      ob     = '0;
      sel    = '0;
      src    = '0;
      status = '0;
      void'($urandom(27871));
      @(negedge reset);
      check("reset state", 32'(cyc_alu), 32'(dut_state));
      check("reset lc", 32'(boot_lc), 32'(dut_lc));
      rotation_test();
      increment_test("increment halfword", 1'b0, lc_addr_t'($urandom), inc_fetches);
      increment_test("increment byte", 1'b1, lc_addr_t'($urandom), inc_fetches);
      increment_test("increment wrap", 1'b0, 26'h3ff_fff8, wrap_fetches);
      load_test(load_rounds);
      priority_test(prio_vectors);
      word_layout_test(word_vectors);
      total = errors + int'(dut.u_props.fail_count);
      $display("errors: %0d from checks, %0d from assertions",
               errors, dut.u_props.fail_count);
      if (total == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire
